// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   localparam int word_width = 16;
   localparam int reg_count  = 8;

   localparam int op_w   = 2;
   localparam int reg_w  = 3;
   localparam int ty_w   = 4;
   localparam int imm_w  = 8;
   localparam int alu_w  = 4;
   localparam int src_w  = 3;
   localparam int jmp_w  = 3;
   localparam int inv_w  = 2;

   // One 16-bit word, two decodings
   typedef union packed {
      struct packed {
         logic [op_w-1:0]  op;
         logic [reg_w-1:0] ra;
         logic [reg_w-1:0] rb;
         logic [ty_w-1:0]  ty;
         logic [ty_w-1:0]  spare;
      } reg_form;
      struct packed {
         logic [op_w-1:0]  op;
         logic [reg_w-1:0] sub;
         logic [reg_w-1:0] rb;
         logic [imm_w-1:0] d;   // Signed offset or value
      } imm_form;
   } inst_t;

   localparam logic [op_w-1:0] op_imm = 2'd2;
   localparam logic [op_w-1:0] op_reg = 2'd3;

   localparam logic [reg_w-1:0] sub_li   = 3'd0;
   localparam logic [reg_w-1:0] sub_addi = 3'd1;
   localparam logic [reg_w-1:0] sub_cmpi = 3'd2;
   localparam logic [reg_w-1:0] sub_b    = 3'd4;
   localparam logic [reg_w-1:0] sub_bcc  = 3'd7;

   localparam logic [reg_w-1:0] cond_be  = 3'd0;
   localparam logic [reg_w-1:0] cond_blt = 3'd1;
   localparam logic [reg_w-1:0] cond_ble = 3'd2;
   localparam logic [reg_w-1:0] cond_bne = 3'd3;

   // Register-form sub-ops, also used as ALU codes
   localparam logic [ty_w-1:0] ty_add = 4'd0;
   localparam logic [ty_w-1:0] ty_sub = 4'd1;
   localparam logic [ty_w-1:0] ty_and = 4'd2;
   localparam logic [ty_w-1:0] ty_or  = 4'd3;
   localparam logic [ty_w-1:0] ty_xor = 4'd4;
   localparam logic [ty_w-1:0] ty_cmp = 4'd5;
   localparam logic [ty_w-1:0] ty_mov = 4'd6;
   localparam logic [ty_w-1:0] ty_out = 4'd13;
   localparam logic [ty_w-1:0] ty_hlt = 4'd15;

   localparam logic [alu_w-1:0] alu_nop = 4'd15;

   localparam logic [jmp_w-1:0] jmp_none = 3'd0;
   localparam logic [jmp_w-1:0] jmp_b    = 3'd1;
   localparam logic [jmp_w-1:0] jmp_be   = 3'd2;
   localparam logic [jmp_w-1:0] jmp_blt  = 3'd3;
   localparam logic [jmp_w-1:0] jmp_ble  = 3'd4;
   localparam logic [jmp_w-1:0] jmp_bne  = 3'd5;

   localparam logic [src_w-1:0] src_reg    = 3'd0;
   localparam logic [src_w-1:0] src_pc     = 3'd1;
   localparam logic [src_w-1:0] src_imm    = 3'd2;
   localparam logic [src_w-1:0] src_zero   = 3'd3;
   localparam logic [src_w-1:0] src_fwd_ex = 3'd4;
   localparam logic [src_w-1:0] src_fwd_wb = 3'd5;

   localparam logic [inv_w-1:0] inv_free = 2'd0;
   localparam logic [inv_w-1:0] inv_ex   = 2'd2;
   localparam logic [inv_w-1:0] inv_wb   = 2'd3;

endpackage

`default_nettype wire

// ==== common/core_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fetch_if;
   cpu_pkg::inst_t                 inst;   // IF/ID word
   logic [cpu_pkg::word_width-1:0] pc;
   logic                           valid;
   logic                           en_pc;
   logic                           en_ifid;
   logic                           flush_ifid;
   logic                           jump;
   logic [cpu_pkg::word_width-1:0] target;

   modport fetch (output inst, pc, valid,
                  input  en_pc, en_ifid, flush_ifid, jump, target);
   modport ctrl  (input  inst, valid,
                  output en_pc, en_ifid, flush_ifid, jump, target);
   modport exec  (input  pc);
endinterface

interface ctrl_if;
   logic [cpu_pkg::alu_w-1:0]      alu_op;
   logic [cpu_pkg::src_w-1:0]      src_a;
   logic [cpu_pkg::src_w-1:0]      src_b;
   logic                           regwrite;
   logic [cpu_pkg::reg_w-1:0]      dest;
   logic [cpu_pkg::reg_w-1:0]      ra;
   logic [cpu_pkg::reg_w-1:0]      rb;
   logic [cpu_pkg::word_width-1:0] imm;
   logic                           out_en;
   logic                           halt_id;
   logic [cpu_pkg::jmp_w-1:0]      jump_kind;
   logic                           en_idex;
   logic                           flush_idex;

   logic [cpu_pkg::reg_count-1:0][cpu_pkg::inv_w-1:0] reg_invalid;
   logic [cpu_pkg::jmp_w-1:0]      jump_state;   // Branch kind now in EX
   logic                           flag_s, flag_z, flag_c, flag_v;
   logic [cpu_pkg::word_width-1:0] alu_result;

   modport ctrl (output alu_op, src_a, src_b, regwrite, dest, ra, rb, imm, out_en,
                        halt_id, jump_kind, en_idex, flush_idex,
                 input  reg_invalid, jump_state, flag_s, flag_z, flag_c, flag_v,
                        alu_result);
   modport exec (input  alu_op, src_a, src_b, regwrite, dest, ra, rb, imm, out_en,
                        halt_id, jump_kind, en_idex, flush_idex,
                 output reg_invalid, jump_state, flag_s, flag_z, flag_c, flag_v,
                        alu_result);
endinterface

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
   input  logic                           clk,
   input  logic                           rst_n,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic [cpu_pkg::word_width-1:0] wb_adr,
   input  logic [cpu_pkg::word_width-1:0] wb_dat_i,
   input  logic                           wb_ack,
   fetch_if.fetch                         fi,
   input  logic                           halted
);

   logic                           busy;   // Wishbone cycle open
   logic                           stale;
   logic                           start;
   logic                           ack_ok;
   logic                           hold_valid;
   logic [cpu_pkg::word_width-1:0] pc;
   logic [cpu_pkg::word_width-1:0] adr_q;
   logic [cpu_pkg::word_width-1:0] hold_pc;
   cpu_pkg::inst_t                 hold_inst;

   assign wb_cyc = busy;
   assign wb_stb = busy;
   assign wb_adr = adr_q;

   assign ack_ok = busy && wb_ack && !stale;
   assign start  = !busy && !halted && !hold_valid && fi.en_pc && !fi.jump;

   always_ff @(posedge clk) begin
      if( !rst_n ) begin
         busy       <= 1'b0;
         stale      <= 1'b0;
         pc         <= '0;
         hold_valid <= 1'b0;
         fi.valid   <= 1'b0;
      end else begin
         if( busy && wb_ack )
            busy <= 1'b0;
         else if( start )
            busy <= 1'b1;

         if( busy && wb_ack )
            stale <= 1'b0;
         else if( busy && fi.jump )
            stale <= 1'b1;   // Response belongs to the old path

         if( fi.jump )
            pc <= fi.target;
         else if( ack_ok )
            pc <= pc + 1'b1;

         if( fi.flush_ifid ) begin
            fi.valid   <= 1'b0;
            hold_valid <= 1'b0;
         end else if( fi.en_ifid ) begin
            fi.valid   <= hold_valid || ack_ok;
            hold_valid <= 1'b0;
         end else if( ack_ok ) begin
            hold_valid <= 1'b1;   // ID stalled
         end
      end
   end

   always_ff @(posedge clk) begin
      if( start )
         adr_q <= pc;
      if( ack_ok && !fi.en_ifid ) begin
         hold_inst <= cpu_pkg::inst_t'(wb_dat_i);
         hold_pc   <= adr_q;
      end
      if( fi.en_ifid ) begin
         if( hold_valid ) begin
            fi.inst <= hold_inst;
            fi.pc   <= hold_pc;
         end else if( ack_ok ) begin
            fi.inst <= cpu_pkg::inst_t'(wb_dat_i);
            fi.pc   <= adr_q;
         end
      end
   end

endmodule

`default_nettype wire

// ==== core/pipe_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_controller (
   fetch_if.ctrl fi,
   ctrl_if.ctrl  ci
);

   logic [cpu_pkg::op_w-1:0]  op;
   logic [cpu_pkg::reg_w-1:0] ra, rb, sub;
   logic [cpu_pkg::ty_w-1:0]  ty;
   logic [cpu_pkg::imm_w-1:0] d;
   logic                      data_hazard;
   logic                      jump;

   assign op  = fi.inst.reg_form.op;
   assign ra  = fi.inst.reg_form.ra;
   assign rb  = fi.inst.reg_form.rb;
   assign ty  = fi.inst.reg_form.ty;
   assign sub = fi.inst.imm_form.sub;
   assign d   = fi.inst.imm_form.d;

   assign ci.ra  = ra;
   assign ci.rb  = rb;
   assign ci.imm = {{(cpu_pkg::word_width-cpu_pkg::imm_w){d[cpu_pkg::imm_w-1]}}, d};

   // OUT must read a settled register
   assign data_hazard = fi.valid && op == cpu_pkg::op_reg && ty == cpu_pkg::ty_out &&
                        ci.reg_invalid[ra] != cpu_pkg::inv_free;

   always_comb begin
      case( ci.jump_state )
         cpu_pkg::jmp_b:   jump = 1'b1;
         cpu_pkg::jmp_be:  jump = ci.flag_z;
         cpu_pkg::jmp_blt: jump = ci.flag_s ^ ci.flag_v;
         cpu_pkg::jmp_ble: jump = ci.flag_z | (ci.flag_s ^ ci.flag_v);
         cpu_pkg::jmp_bne: jump = !ci.flag_z;
         default:          jump = 1'b0;
      endcase
   end

   assign fi.jump   = jump;
   assign fi.target = ci.alu_result;   // pc + 1 + d from EX

   always_comb begin
      fi.en_pc      = 1'b1;
      fi.en_ifid    = 1'b1;
      fi.flush_ifid = 1'b0;
      ci.en_idex    = 1'b1;
      ci.flush_idex = 1'b0;
      if( jump ) begin
         fi.flush_ifid = 1'b1;
         ci.flush_idex = 1'b1;
      end else if( data_hazard ) begin
         fi.en_pc      = 1'b0;
         fi.en_ifid    = 1'b0;
         ci.flush_idex = 1'b1;   // Bubble into EX
      end
   end

   always_comb begin
      ci.alu_op    = cpu_pkg::alu_nop;
      ci.src_a     = cpu_pkg::src_reg;
      ci.src_b     = cpu_pkg::src_reg;
      ci.regwrite  = 1'b0;
      ci.dest      = ra;
      ci.out_en    = 1'b0;
      ci.halt_id   = 1'b0;
      ci.jump_kind = cpu_pkg::jmp_none;

      case( ci.reg_invalid[ra] )
         cpu_pkg::inv_ex: ci.src_b = cpu_pkg::src_fwd_ex;
         cpu_pkg::inv_wb: ci.src_b = cpu_pkg::src_fwd_wb;
         default:         ci.src_b = cpu_pkg::src_reg;
      endcase
      case( ci.reg_invalid[rb] )
         cpu_pkg::inv_ex: ci.src_a = cpu_pkg::src_fwd_ex;
         cpu_pkg::inv_wb: ci.src_a = cpu_pkg::src_fwd_wb;
         default:         ci.src_a = cpu_pkg::src_reg;
      endcase

      if( fi.valid ) begin
         if( op == cpu_pkg::op_imm ) begin
            ci.src_b = cpu_pkg::src_imm;
            ci.dest  = rb;
            case( sub )
               cpu_pkg::sub_li: begin
                  ci.regwrite = 1'b1;
                  ci.alu_op   = cpu_pkg::ty_mov;
                  ci.src_a    = cpu_pkg::src_imm;
                  ci.src_b    = cpu_pkg::src_zero;
               end
               cpu_pkg::sub_addi: begin
                  ci.regwrite = 1'b1;
                  ci.alu_op   = cpu_pkg::ty_add;
               end
               cpu_pkg::sub_cmpi: ci.alu_op = cpu_pkg::ty_cmp;
               cpu_pkg::sub_b: begin
                  ci.jump_kind = cpu_pkg::jmp_b;
                  ci.src_a     = cpu_pkg::src_pc;
               end
               cpu_pkg::sub_bcc: begin
                  ci.src_a = cpu_pkg::src_pc;
                  case( rb )   // Condition lives in rb
                     cpu_pkg::cond_be:  ci.jump_kind = cpu_pkg::jmp_be;
                     cpu_pkg::cond_blt: ci.jump_kind = cpu_pkg::jmp_blt;
                     cpu_pkg::cond_ble: ci.jump_kind = cpu_pkg::jmp_ble;
                     cpu_pkg::cond_bne: ci.jump_kind = cpu_pkg::jmp_bne;
                     default:           ci.jump_kind = cpu_pkg::jmp_none;
                  endcase
               end
               default: ;
            endcase
         end else if( op == cpu_pkg::op_reg ) begin
            case( ty )
               cpu_pkg::ty_add, cpu_pkg::ty_sub, cpu_pkg::ty_and, cpu_pkg::ty_or,
               cpu_pkg::ty_xor, cpu_pkg::ty_mov: begin
                  ci.alu_op   = ty;
                  ci.regwrite = 1'b1;
               end
               cpu_pkg::ty_cmp: ci.alu_op  = ty;
               cpu_pkg::ty_out: ci.out_en  = !data_hazard;
               cpu_pkg::ty_hlt: ci.halt_id = 1'b1;
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== core/exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
   input  logic                           clk,
   input  logic                           rst_n,
   ctrl_if.exec                           ci,
   fetch_if.exec                          fi,
   output logic [cpu_pkg::word_width-1:0] out_data,
   output logic                           out_valid,
   output logic                           halted
);

   logic [cpu_pkg::word_width-1:0] rf [cpu_pkg::reg_count];
   logic [cpu_pkg::word_width-1:0] a_id, b_id;

   logic [cpu_pkg::alu_w-1:0]      alu_op_ex;
   logic [cpu_pkg::jmp_w-1:0]      jump_kind_ex;
   logic                           regwrite_ex, out_en_ex, halt_ex;
   logic [cpu_pkg::reg_w-1:0]      dest_ex;
   logic                           fwd_a_ex, fwd_b_ex;
   logic [cpu_pkg::word_width-1:0] a_ex, b_ex;

   logic [cpu_pkg::word_width-1:0] op_a, op_b, result;
   logic [cpu_pkg::word_width:0]   sum, diff;
   logic                           carry, ovf, set_flags;

   logic                           regwrite_wb;
   logic [cpu_pkg::reg_w-1:0]      dest_wb;
   logic [cpu_pkg::word_width-1:0] wb_result;

   function automatic logic [cpu_pkg::word_width-1:0] sel_operand(
      input logic [cpu_pkg::src_w-1:0]      src,
      input logic [cpu_pkg::word_width-1:0] reg_val,
      input logic [cpu_pkg::word_width-1:0] pc,
      input logic [cpu_pkg::word_width-1:0] imm,
      input logic [cpu_pkg::word_width-1:0] wb_val);
      case( src )
         cpu_pkg::src_reg:    return reg_val;
         cpu_pkg::src_pc:     return pc;
         cpu_pkg::src_imm:    return imm;
         cpu_pkg::src_fwd_wb: return wb_val;   // Register written this cycle
         default:             return '0;       // Zero, or EX forward taken later
      endcase
   endfunction

   assign a_id = sel_operand(ci.src_a, rf[ci.rb], fi.pc, ci.imm, wb_result);
   assign b_id = sel_operand(ci.src_b, rf[ci.ra], fi.pc, ci.imm, wb_result);

   always_ff @(posedge clk) begin
      if( !rst_n || ci.flush_idex ) begin
         alu_op_ex    <= cpu_pkg::alu_nop;
         jump_kind_ex <= cpu_pkg::jmp_none;
         regwrite_ex  <= 1'b0;
         out_en_ex    <= 1'b0;
         halt_ex      <= 1'b0;
      end else if( ci.en_idex ) begin
         alu_op_ex    <= ci.alu_op;
         jump_kind_ex <= ci.jump_kind;
         regwrite_ex  <= ci.regwrite;
         out_en_ex    <= ci.out_en;
         halt_ex      <= ci.halt_id;
      end
   end

   always_ff @(posedge clk) begin
      if( ci.en_idex ) begin
         dest_ex  <= ci.dest;
         fwd_a_ex <= ci.src_a == cpu_pkg::src_fwd_ex;
         fwd_b_ex <= ci.src_b == cpu_pkg::src_fwd_ex;
         a_ex     <= a_id;
         b_ex     <= b_id;
      end
   end

   assign op_a = fwd_a_ex ? wb_result : a_ex;
   assign op_b = fwd_b_ex ? wb_result : b_ex;
   assign sum  = {1'b0, op_b} + {1'b0, op_a};
   assign diff = {1'b0, op_b} + {1'b0, ~op_a} + 1'b1;

   always_comb begin
      carry = 1'b0;
      ovf   = 1'b0;
      case( alu_op_ex )
         cpu_pkg::ty_add: begin
            result = sum[cpu_pkg::word_width-1:0];
            carry  = sum[cpu_pkg::word_width];
            ovf    = op_a[cpu_pkg::word_width-1] == op_b[cpu_pkg::word_width-1] &&
                     result[cpu_pkg::word_width-1] != op_b[cpu_pkg::word_width-1];
         end
         cpu_pkg::ty_sub, cpu_pkg::ty_cmp: begin   // B - A
            result = diff[cpu_pkg::word_width-1:0];
            carry  = diff[cpu_pkg::word_width];
            ovf    = op_a[cpu_pkg::word_width-1] != op_b[cpu_pkg::word_width-1] &&
                     result[cpu_pkg::word_width-1] != op_b[cpu_pkg::word_width-1];
         end
         cpu_pkg::ty_and: result = op_b & op_a;
         cpu_pkg::ty_or:  result = op_b | op_a;
         cpu_pkg::ty_xor: result = op_b ^ op_a;
         cpu_pkg::ty_mov: result = op_a;
         default:         result = op_a + op_b + 1'b1;   // Branch target pc + 1 + d
      endcase
   end

   assign set_flags = !halted && (alu_op_ex == cpu_pkg::ty_add ||
                      alu_op_ex == cpu_pkg::ty_sub || alu_op_ex == cpu_pkg::ty_cmp);
   assign ci.alu_result = result;
   assign ci.jump_state = halted ? cpu_pkg::jmp_none : jump_kind_ex;

   always_ff @(posedge clk) begin
      if( !rst_n ) begin
         ci.flag_s <= 1'b0;
         ci.flag_z <= 1'b0;
         ci.flag_c <= 1'b0;
         ci.flag_v <= 1'b0;
      end else if( set_flags ) begin
         ci.flag_s <= result[cpu_pkg::word_width-1];
         ci.flag_z <= result == '0;
         ci.flag_c <= carry;
         ci.flag_v <= ovf;
      end
   end

   always_ff @(posedge clk) begin
      if( !rst_n ) begin
         regwrite_wb <= 1'b0;
         out_valid   <= 1'b0;
         halted      <= 1'b0;
      end else begin
         regwrite_wb <= regwrite_ex && !halted;
         out_valid   <= out_en_ex && !halted;
         if( halt_ex )
            halted <= 1'b1;   // Sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      dest_wb   <= dest_ex;
      wb_result <= result;
      if( out_en_ex )
         out_data <= op_b;
      if( regwrite_wb )
         rf[dest_wb] <= wb_result;
   end

   always_comb begin
      for( int r = 0; r < cpu_pkg::reg_count; r++ ) begin
         if( regwrite_ex && dest_ex == cpu_pkg::reg_w'(r) )
            ci.reg_invalid[r] = cpu_pkg::inv_ex;
         else if( regwrite_wb && dest_wb == cpu_pkg::reg_w'(r) )
            ci.reg_invalid[r] = cpu_pkg::inv_wb;
         else
            ci.reg_invalid[r] = cpu_pkg::inv_free;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
   input  logic                           clk,
   input  logic                           rst_n,
   output logic                           wb_cyc,
   output logic                           wb_stb,
   output logic [cpu_pkg::word_width-1:0] wb_adr,
   input  logic [cpu_pkg::word_width-1:0] wb_dat_i,
   input  logic                           wb_ack,
   output logic [cpu_pkg::word_width-1:0] out_data,
   output logic                           out_valid,
   output logic                           halted
);

   fetch_if fi ();
   ctrl_if  ci ();

   fetch_unit u_fetch (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_adr   (wb_adr),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .fi       (fi.fetch),
      .halted   (halted)
   );

   pipe_controller u_ctrl (
      .fi (fi.ctrl),
      .ci (ci.ctrl)
   );

   exec_stage u_exec (
      .clk       (clk),
      .rst_n     (rst_n),
      .ci        (ci.exec),
      .fi        (fi.exec),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted)
   );

endmodule

`default_nettype wire

// ==== tests/tb_cpu_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_assert (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           wb_cyc,
   input logic                           wb_stb,
   input logic                           wb_ack,
   input logic [cpu_pkg::word_width-1:0] wb_adr,
   input logic                           jump,
   input logic                           en_ifid,
   input logic                           ifid_valid,
   input cpu_pkg::inst_t                 ifid_inst,
   input logic                           out_valid
);

   int fail_count = 0;

   stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_stb |-> wb_cyc)
      else begin
         fail_count++;
         $error("wb_stb high without wb_cyc");
      end

   // Address held for the whole classic cycle
   adr_held: assert property (@(posedge clk) disable iff (!rst_n)
                              wb_stb && !wb_ack |=> $stable(wb_adr))
      else begin
         fail_count++;
         $error("wb_adr changed before wb_ack");
      end

   // Taken branch leaves a bubble in decode
   jump_flush: assert property (@(posedge clk) disable iff (!rst_n)
                                jump |=> !ifid_valid)
      else begin
         fail_count++;
         $error("taken branch did not flush the IF/ID register");
      end

   stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                !en_ifid |=> ifid_valid && $stable(ifid_inst))
      else begin
         fail_count++;
         $error("stalled IF/ID register lost its instruction");
      end

   out_single: assert property (@(posedge clk) disable iff (!rst_n)
                                out_valid |=> !out_valid)
      else begin
         fail_count++;
         $error("out_valid high on two cycles in a row");
      end

endmodule

bind cpu_top tb_cpu_assert props0 (
   .clk        (clk),
   .rst_n      (rst_n),
   .wb_cyc     (wb_cyc),
   .wb_stb     (wb_stb),
   .wb_ack     (wb_ack),
   .wb_adr     (wb_adr),
   .jump       (fi.jump),
   .en_ifid    (fi.en_ifid),
   .ifid_valid (fi.valid),
   .ifid_inst  (fi.inst),
   .out_valid  (out_valid)
);

`default_nettype wire

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

   localparam int reset_cycles  = 4;
   localparam int loop_factor   = 4;
   localparam int total_words   = 58;   // Sum of all program lengths
   localparam int test_count    = 5;
   localparam int test_overhead = 40;   // Reset and quiet window per test
   localparam int watchdog_cycles = total_words * 6 * loop_factor +
                                    test_count * test_overhead;

   logic                           clk;
   logic                           rst_n = 1'b0;
   logic                           wb_cyc, wb_stb;
   logic [cpu_pkg::word_width-1:0] wb_adr;
   logic [cpu_pkg::word_width-1:0] wb_dat_i = '0;
   logic                           wb_ack = 1'b0;
   logic [cpu_pkg::word_width-1:0] out_data;
   logic                           out_valid, halted;

   cpu_pkg::inst_t                 imem [256];
   int                             prog_len;
   logic [cpu_pkg::word_width-1:0] expected [$];
   logic [cpu_pkg::word_width-1:0] outs [$];
   cpu_pkg::inst_t                 first_inst;
   logic                           first_seen;
   int                             checks = 0;
   int                             errors = 0;

   cpu_top dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_adr    (wb_adr),
      .wb_dat_i  (wb_dat_i),
      .wb_ack    (wb_ack),
      .out_data  (out_data),
      .out_valid (out_valid),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Instruction memory, zero to three wait states per transfer
   initial begin
      int wait_left;
      void'($urandom(32'hc3aa));
      wait_left = 0;
      forever begin
         @(posedge clk);
         if (!wb_stb || wb_ack) begin
            wb_ack <= 1'b0;
            wait_left = $urandom % 4;
         end else if (wait_left == 0) begin
            wb_ack   <= 1'b1;
            wb_dat_i <= imem[wb_adr[7:0]];
         end else begin
            wait_left--;
         end
      end
   end

   always @(negedge clk) begin
      if (!rst_n) begin
         outs.delete();
         first_seen = 1'b0;
      end else begin
         if (out_valid)
            outs.push_back(out_data);
         if (dut0.fi.valid && !first_seen) begin   // First word to reach decode
            first_inst = dut0.fi.inst;
            first_seen = 1'b1;
         end
      end
   end

   task automatic check_out(input string name, input logic [cpu_pkg::word_width-1:0] exp,
                            input logic [cpu_pkg::word_width-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("error %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_inst(input string name, input cpu_pkg::inst_t exp,
                             input cpu_pkg::inst_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("error %s: expected inst %h, actual inst %h", name, exp, act);
      end
   endtask

   task automatic check_halt(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("error %s: expected halted %b, actual halted %b", name, exp, act);
      end
   endtask

   task automatic start_program();
      prog_len = 0;
      expected.delete();
      for (int a = 0; a < 256; a++) begin
         imem[a] = {cpu_pkg::op_reg, a[2:0], a[5:3], cpu_pkg::ty_hlt, 2'b00, a[7:6]};   // HLT
      end
   endtask

   task automatic emit_imm(input logic [cpu_pkg::reg_w-1:0] sub, input int r, input int d);
      cpu_pkg::inst_t w;
      w.imm_form.op  = cpu_pkg::op_imm;
      w.imm_form.sub = sub;
      w.imm_form.rb  = cpu_pkg::reg_w'(r);
      w.imm_form.d   = cpu_pkg::imm_w'(d);
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic emit_reg(input logic [cpu_pkg::ty_w-1:0] ty, input int ra, input int rb);
      cpu_pkg::inst_t w;
      w.reg_form.op    = cpu_pkg::op_reg;
      w.reg_form.ra    = cpu_pkg::reg_w'(ra);
      w.reg_form.rb    = cpu_pkg::reg_w'(rb);
      w.reg_form.ty    = ty;
      w.reg_form.spare = '0;
      imem[prog_len] = w;
      prog_len++;
   endtask

   task automatic run_program(input string name);
      int limit;
      int cycles;
      int n;
      logic bus_seen;
      limit = prog_len * 6 * loop_factor;
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      cycles = 0;
      while (!halted && cycles < limit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         errors++;
         $display("%s: core did not halt within %0d cycles", name, limit);
      end
      repeat (6) @(negedge clk);   // Fetch in flight ends
      bus_seen = 1'b0;
      repeat (12) begin
         @(negedge clk);
         if (wb_cyc || wb_stb)
            bus_seen = 1'b1;
      end
      if (bus_seen) begin
         errors++;
         $display("%s: wb_cyc or wb_stb rose again after the halt", name);
      end
      check_halt(name, 1'b1, halted);
      if (outs.size() != expected.size()) begin
         errors++;
         $display("%s: %0d output words expected, %0d seen", name, expected.size(), outs.size());
      end
      n = (outs.size() < expected.size()) ? outs.size() : expected.size();
      for (int i = 0; i < n; i++) begin
         check_out(name, expected[i], outs[i]);
      end
      if (!first_seen) begin
         errors++;
         $display("%s: no instruction ever reached decode", name);
      end else begin
         check_inst(name, imem[0], first_inst);
      end
   endtask

   task automatic arith_immediate();
      start_program();
      emit_imm(cpu_pkg::sub_li, 2, 25);
      emit_imm(cpu_pkg::sub_addi, 2, -7);
      emit_reg(cpu_pkg::ty_out, 2, 0);
      emit_imm(cpu_pkg::sub_li, 3, -100);
      emit_imm(cpu_pkg::sub_addi, 3, 120);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_reg(cpu_pkg::ty_hlt, 0, 0);
      expected = {16'd18, 16'd20};
      run_program("arith_immediate");
   endtask

   task automatic reg_ops();
      start_program();
      emit_imm(cpu_pkg::sub_li, 1, 12);
      emit_imm(cpu_pkg::sub_li, 2, 5);
      emit_reg(cpu_pkg::ty_add, 1, 2);
      emit_reg(cpu_pkg::ty_sub, 1, 2);
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_reg(cpu_pkg::ty_mov, 3, 1);
      emit_reg(cpu_pkg::ty_xor, 3, 2);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_reg(cpu_pkg::ty_or, 3, 2);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_reg(cpu_pkg::ty_and, 3, 2);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_reg(cpu_pkg::ty_sub, 2, 1);   // 5 - 12 goes negative
      emit_reg(cpu_pkg::ty_out, 2, 0);
      emit_reg(cpu_pkg::ty_hlt, 0, 0);
      expected = {16'd12, 16'd9, 16'd13, 16'd5, 16'hfff9};
      run_program("reg_ops");
   endtask

   task automatic compare_branch();
      start_program();
      emit_imm(cpu_pkg::sub_li, 1, 5);
      emit_imm(cpu_pkg::sub_li, 2, 9);
      emit_imm(cpu_pkg::sub_li, 3, 21);
      emit_reg(cpu_pkg::ty_cmp, 1, 2);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_blt, 2);   // Taken, skips two
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_reg(cpu_pkg::ty_out, 2, 0);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_be, 1);
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_imm(cpu_pkg::sub_cmpi, 2, 9);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_bne, 1);
      emit_reg(cpu_pkg::ty_out, 2, 0);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_ble, 1);
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_be, 1);
      emit_reg(cpu_pkg::ty_out, 2, 0);
      emit_reg(cpu_pkg::ty_cmp, 2, 1);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_ble, 1);
      emit_reg(cpu_pkg::ty_out, 3, 0);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_bne, 1);
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_reg(cpu_pkg::ty_hlt, 0, 0);
      expected = {16'd21, 16'd5, 16'd9, 16'd21};
      run_program("compare_branch");
   endtask

   task automatic countdown_loop();
      start_program();
      emit_imm(cpu_pkg::sub_li, 1, 3);
      emit_reg(cpu_pkg::ty_out, 1, 0);
      emit_imm(cpu_pkg::sub_cmpi, 1, 0);
      emit_imm(cpu_pkg::sub_bcc, cpu_pkg::cond_be, 2);   // Exit to HLT at 6
      emit_imm(cpu_pkg::sub_addi, 1, -1);
      emit_imm(cpu_pkg::sub_b, 0, -5);   // Back to the OUT at 1
      emit_reg(cpu_pkg::ty_hlt, 0, 0);
      expected = {16'd3, 16'd2, 16'd1, 16'd0};
      run_program("countdown_loop");
   endtask

   task automatic halt_stop();
      start_program();
      emit_imm(cpu_pkg::sub_li, 4, 77);
      emit_reg(cpu_pkg::ty_out, 4, 0);
      emit_reg(cpu_pkg::ty_hlt, 0, 0);
      emit_reg(cpu_pkg::ty_out, 4, 0);
      emit_imm(cpu_pkg::sub_li, 4, 1);
      emit_reg(cpu_pkg::ty_out, 4, 0);
      expected = {16'd77};
      run_program("halt_stop");
   endtask

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog: run stopped after %0d cycles", watchdog_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      arith_immediate();
      reg_ops();
      compare_branch();
      countdown_loop();
      halt_stop();
      errors = errors + dut0.props0.fail_count;
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
common/cpu_pkg.sv
common/core_if.sv
rtl/fetch_unit.sv
core/pipe_controller.sv
core/exec_stage.sv
rtl/cpu_top.sv
tests/tb_cpu_assert.sv
tests/tb_cpu.sv
